//--- vlog.f
source/pipe_pkg.sv
source/pipe_delay_line.sv
source/pipe_misc.sv
source/pipe_lane.sv
source/pipe_pipeline.sv
verification/pipe_clk_gen.sv
verification/pipe_pipeline_tb.sv

//--- Makefile
# Verilator build and run for the PIPE pipeline stage.
# Override on the command line, e.g. make run STAGES=2

VERILATOR ?= verilator
STAGES    ?= 1
TOP       ?= pipe_pipeline_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir_s$(STAGES)
LOG       ?= sim_s$(STAGES).log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, the file list or this Makefile changes
$(SIM_BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Gpipe_stages=$(STAGES) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "^All tests passed$$" $(LOG); then \
		echo "run with STAGES=$(STAGES) passed"; \
	else \
		echo "run with STAGES=$(STAGES) failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir_s0 obj_dir_s1 obj_dir_s2 $(BUILD_DIR)
	rm -f sim_s0.log sim_s1.log sim_s2.log $(LOG)

//--- verification/pipe_pipeline_tb.sv
`default_nettype none

module pipe_pipeline_tb #(
    parameter int pipe_stages = 1
);

    timeunit 1ns;
    timeprecision 1ps;

    import pipe_pkg::*;

    // ------------------------------------------------------------------
    // stimulus table.
    // ------------------------------------------------------------------

    typedef struct packed {
        logic                          rst;
        pipe_tx_ctrl_t                 ctrl;
        pipe_lane_tx_t [num_lanes-1:0] tx;
        pipe_lane_rx_t [num_lanes-1:0] rx;
    } stim_row_t;

    localparam int n_directed     = 4 + int'(margin_max) + 1;
    localparam int n_random       = 32;
    localparam int table_len      = n_directed + n_random;
    localparam int rst_row        = n_directed + 12;
    localparam int rst_len        = 2;
    localparam int seed           = 32'h47d27989;
    localparam int clk_period_ns  = 10;
    localparam int timeout_cycles = table_len + pipe_stages + 10;

    logic          pipe_clk;
    logic          rst_n;
    logic          rst_req;
    pipe_tx_ctrl_t tx_ctrl_i;
    pipe_tx_ctrl_t tx_ctrl_o;
    pipe_lane_tx_t lane_tx_i [num_lanes];
    pipe_lane_tx_t lane_tx_o [num_lanes];
    pipe_lane_rx_t lane_rx_i [num_lanes];
    pipe_lane_rx_t lane_rx_o [num_lanes];

    stim_row_t     stim_table [table_len];
    stim_row_t     hist [$];
    stim_row_t     cur_row;
    stim_row_t     idle_row;
    logic          cur_rst;
    int            ctrl_errors;
    int            tx_errors;
    int            rx_errors;

    pipe_clk_gen #(
        .half_period_ns (clk_period_ns / 2),
        .rst_cycles     (2)
    ) i_clk_gen (
        .rst_req_i (rst_req),
        .pipe_clk  (pipe_clk),
        .rst_n     (rst_n)
    );

    pipe_pipeline #(
        .pipe_stages (pipe_stages)
    ) i_pipe_pipeline (
        .pipe_clk  (pipe_clk),
        .rst_n     (rst_n),
        .tx_ctrl_i (tx_ctrl_i),
        .tx_ctrl_o (tx_ctrl_o),
        .lane_tx_i (lane_tx_i),
        .lane_tx_o (lane_tx_o),
        .lane_rx_i (lane_rx_i),
        .lane_rx_o (lane_rx_o)
    );

    // ------------------------------------------------------------------
    // row builders.
    // ------------------------------------------------------------------

    // inactive PIPE levels: transmitter in reset, lanes idle in P1.
    function automatic stim_row_t reset_row();
        stim_row_t row;
        row = '0;
        row.ctrl.tx_reset = 1'b1;
        row.ctrl.deemph   = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
            row.tx[l].elec_idle = 1'b1;
            row.tx[l].powerdown = 2'd2;
            row.rx[l].elec_idle = 1'b1;
        end
        return row;
    endfunction

    function automatic stim_row_t all_ones_row();
        stim_row_t row;
        row = '0;
        row.ctrl          = '1;
        row.ctrl.rcvr_det = 1'b0;
        row.ctrl.margin   = margin_max;
        for (int l = 0; l < num_lanes; l++) begin
            row.tx[l]           = '1;
            row.rx[l]           = '1;
            row.rx[l].elec_idle = 1'b0;
        end
        return row;
    endfunction

    function automatic stim_row_t alternating_row(input logic invert);
        stim_row_t row;
        row = '0;
        row.ctrl = invert ? 8'haa : 8'h55;
        // 8'haa would land on a reserved margin code.
        if (invert) begin
            row.ctrl.margin = 3'b010;
        end
        for (int l = 0; l < num_lanes; l++) begin
            row.tx[l] = invert ? 23'h2aaaaa : 23'h555555;
            row.rx[l] = invert ? 24'h555555 : 24'haaaaaa;
        end
        return row;
    endfunction

    // one margin code per row, a distinct pattern on every lane.
    function automatic stim_row_t margin_row(input int k);
        stim_row_t row;
        row = '0;
        row.ctrl.rcvr_det = k[0];
        row.ctrl.tx_reset = 1'b0;
        row.ctrl.rate     = k[1];
        row.ctrl.deemph   = ~k[0];
        row.ctrl.margin   = 3'(k);
        row.ctrl.swing    = k[2];
        for (int l = 0; l < num_lanes; l++) begin
            row.tx[l].data       = 16'((l + 1) * 16'h1111) ^ 16'(k);
            row.tx[l].datak      = lane_k_w'(l);
            row.tx[l].compliance = (l == 3);
            row.tx[l].polarity   = l[0];
            row.rx[l].data       = 16'((num_lanes - l) * 16'h0f0f) ^ 16'(k << 8);
            row.rx[l].datak      = ~lane_k_w'(l);
            row.rx[l].valid      = 1'b1;
            row.rx[l].status     = 3'(l);
            row.rx[l].phy_status = (k == 0);
        end
        return row;
    endfunction

    function automatic stim_row_t random_row();
        stim_row_t row;
        row = '0;
        row.ctrl        = 8'($urandom);
        row.ctrl.margin = 3'($urandom % (margin_max + 1));
        if (row.ctrl.tx_reset) begin
            row.ctrl.rcvr_det = 1'b0;
        end
        for (int l = 0; l < num_lanes; l++) begin
            row.tx[l] = 23'($urandom);
            row.rx[l] = 24'($urandom);
            if (row.rx[l].elec_idle) begin
                row.rx[l].valid = 1'b0;
            end
        end
        return row;
    endfunction

    task automatic build_table();
        stim_table[0] = reset_row();
        stim_table[1] = all_ones_row();
        stim_table[2] = alternating_row(1'b0);
        stim_table[3] = alternating_row(1'b1);
        for (int k = 0; k <= int'(margin_max); k++) begin
            stim_table[4 + k] = margin_row(k);
        end
        for (int i = n_directed; i < table_len; i++) begin
            stim_table[i] = random_row();
        end
        for (int i = 0; i < rst_len; i++) begin
            stim_table[rst_row + i].rst = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------
    // drive, reference model and checks.
    // ------------------------------------------------------------------

    task automatic drive_row(input stim_row_t row);
        rst_req   = row.rst;
        tx_ctrl_i = row.ctrl;
        for (int l = 0; l < num_lanes; l++) begin
            lane_tx_i[l] = row.tx[l];
            lane_rx_i[l] = row.rx[l];
        end
    endtask

    // hist holds the rows inside the pipe, newest at the front.
    task automatic model_step();
        if (pipe_stages > 0) begin
            if (cur_rst) begin
                hist.delete();
                for (int s = 0; s < pipe_stages; s++) begin
                    hist.push_back(reset_row());
                end
            end else begin
                hist.push_front(cur_row);
                hist.delete(pipe_stages);
            end
        end
    endtask

    task automatic check_outputs();
        stim_row_t exp_row;
        if (pipe_stages == 0) begin
            exp_row = cur_row;
        end else begin
            exp_row = hist[hist.size() - 1];
        end
        assert (tx_ctrl_o == exp_row.ctrl) else begin
            ctrl_errors++;
            $display("mismatch at %0t: tx_ctrl_o got %h, expected %h",
                     $time, tx_ctrl_o, exp_row.ctrl);
        end
        for (int l = 0; l < num_lanes; l++) begin
            assert (lane_tx_o[l] == exp_row.tx[l]) else begin
                tx_errors++;
                $display("mismatch at %0t: lane_tx_o[%0d] got %h, expected %h",
                         $time, l, lane_tx_o[l], exp_row.tx[l]);
            end
            assert (lane_rx_o[l] == exp_row.rx[l]) else begin
                rx_errors++;
                $display("mismatch at %0t: lane_rx_o[%0d] got %h, expected %h",
                         $time, l, lane_rx_o[l], exp_row.rx[l]);
            end
        end
    endtask

    task automatic run_cycle(input stim_row_t row);
        @(posedge pipe_clk);
        model_step();
        #1;
        drive_row(row);
        cur_row = row;
        #4;
        cur_rst = rst_n;
        check_outputs();
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog.
    // ------------------------------------------------------------------

    initial begin
        stim_row_t busy_row;
        ctrl_errors = 0;
        tx_errors   = 0;
        rx_errors   = 0;
        void'($urandom(seed));
        idle_row    = reset_row();
        // live data during power-on reset, so only the reset gives idle levels.
        busy_row    = margin_row(1);
        drive_row(busy_row);
        cur_row = busy_row;
        for (int s = 0; s < pipe_stages; s++) begin
            hist.push_back(reset_row());
        end
        build_table();
        #2;
        cur_rst = rst_n;
        while (cur_rst) begin
            run_cycle(busy_row);
        end
        for (int i = 0; i < table_len; i++) begin
            run_cycle(stim_table[i]);
        end
        // flush the last rows out of the pipe.
        repeat (pipe_stages + 1) begin
            run_cycle(idle_row);
        end
        $display("errors: tx_ctrl %0d, lane_tx %0d, lane_rx %0d",
                 ctrl_errors, tx_errors, rx_errors);
        if (ctrl_errors + tx_errors + rx_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period_ns);
        $display("timeout: run did not finish within %0d clock periods", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/pipe_clk_gen.sv
`default_nettype none

module pipe_clk_gen #(
    parameter int half_period_ns = 5,
    parameter int rst_cycles     = 2
) (
    input  logic rst_req_i,
    output logic pipe_clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    logic por_q;

    initial begin
        pipe_clk = 1'b0;
        forever #(half_period_ns) pipe_clk = ~pipe_clk;
    end

    // power-on reset ends just after an edge, never on one.
    initial begin
        por_q = 1'b1;
        repeat (rst_cycles) @(posedge pipe_clk);
        #1;
        por_q = 1'b0;
    end

    // rst_n is active high here.
    assign rst_n = por_q | rst_req_i;

endmodule

`default_nettype wire

//--- source/pipe_pipeline.sv
`default_nettype none

module pipe_pipeline #(
    parameter int pipe_stages = 1
) (
    input  logic                    pipe_clk,
    input  logic                    rst_n,

    // shared transmit controls.
    input  pipe_pkg::pipe_tx_ctrl_t tx_ctrl_i,
    output pipe_pkg::pipe_tx_ctrl_t tx_ctrl_o,

    // per-lane transmit, core to transceiver.
    input  pipe_pkg::pipe_lane_tx_t lane_tx_i [pipe_pkg::num_lanes],
    output pipe_pkg::pipe_lane_tx_t lane_tx_o [pipe_pkg::num_lanes],

    // per-lane receive, transceiver to core.
    input  pipe_pkg::pipe_lane_rx_t lane_rx_i [pipe_pkg::num_lanes],
    output pipe_pkg::pipe_lane_rx_t lane_rx_o [pipe_pkg::num_lanes]
);

    import pipe_pkg::*;

    // ------------------------------------------------------------------
    // shared control slice.
    // ------------------------------------------------------------------

    pipe_misc #(
        .pipe_stages (pipe_stages)
    ) i_pipe_misc (
        .pipe_clk  (pipe_clk),
        .rst_n     (rst_n),
        .tx_ctrl_i (tx_ctrl_i),
        .tx_ctrl_o (tx_ctrl_o)
    );

    // ------------------------------------------------------------------
    // lane slices.
    // ------------------------------------------------------------------

    // every lane gets the same depth so the lanes stay aligned.
    generate
        for (genvar lane = 0; lane < num_lanes; lane++) begin : g_lane

            pipe_lane #(
                .pipe_stages (pipe_stages)
            ) i_pipe_lane (
                .pipe_clk (pipe_clk),
                .rst_n    (rst_n),
                .tx_i     (lane_tx_i[lane]),
                .tx_o     (lane_tx_o[lane]),
                .rx_i     (lane_rx_i[lane]),
                .rx_o     (lane_rx_o[lane])
            );

        end
    endgenerate

endmodule

`default_nettype wire

//--- source/pipe_lane.sv
`default_nettype none

module pipe_lane #(
    parameter int pipe_stages = 1
) (
    input  logic                   pipe_clk,
    input  logic                   rst_n,
    input  pipe_pkg::pipe_lane_tx_t tx_i,
    output pipe_pkg::pipe_lane_tx_t tx_o,
    input  pipe_pkg::pipe_lane_rx_t rx_i,
    output pipe_pkg::pipe_lane_rx_t rx_o
);

    import pipe_pkg::*;

    // ------------------------------------------------------------------
    // transmit direction, core to transceiver.
    // ------------------------------------------------------------------

    pipe_delay_line #(
        .payload_t   (pipe_lane_tx_t),
        .pipe_stages (pipe_stages),
        .rst_val     (pipe_lane_tx_rst)
    ) i_tx_delay (
        .pipe_clk (pipe_clk),
        .rst_n    (rst_n),
        .d_i      (tx_i),
        .q_o      (tx_o)
    );

    // ------------------------------------------------------------------
    // receive direction, transceiver to core.
    // ------------------------------------------------------------------

    pipe_delay_line #(
        .payload_t   (pipe_lane_rx_t),
        .pipe_stages (pipe_stages),
        .rst_val     (pipe_lane_rx_rst)
    ) i_rx_delay (
        .pipe_clk (pipe_clk),
        .rst_n    (rst_n),
        .d_i      (rx_i),
        .q_o      (rx_o)
    );

    // an idle receiver has no symbols to deliver.
    a_rx_valid_not_idle: assert property (
        @(posedge pipe_clk) disable iff (rst_n)
        !(rx_i.valid && rx_i.elec_idle)
    ) else $error("rx data valid while lane reports electrical idle");

endmodule

`default_nettype wire

//--- source/pipe_misc.sv
`default_nettype none

module pipe_misc #(
    parameter int pipe_stages = 1
) (
    input  logic                   pipe_clk,
    input  logic                   rst_n,
    input  pipe_pkg::pipe_tx_ctrl_t tx_ctrl_i,
    output pipe_pkg::pipe_tx_ctrl_t tx_ctrl_o
);

    import pipe_pkg::*;

    // ------------------------------------------------------------------
    // shared control retiming.
    // ------------------------------------------------------------------

    generate
        if (pipe_stages == 0) begin : g_stages_0

            assign tx_ctrl_o = tx_ctrl_i;

        end else if (pipe_stages == 1) begin : g_stages_1

            pipe_tx_ctrl_t ctrl_q;

            always_ff @(posedge pipe_clk) begin
                if (rst_n) begin
                    ctrl_q <= pipe_tx_ctrl_rst;
                end else begin
                    ctrl_q <= tx_ctrl_i;
                end
            end

            assign tx_ctrl_o = ctrl_q;

        end else if (pipe_stages == 2) begin : g_stages_2

            pipe_tx_ctrl_t ctrl_q;
            pipe_tx_ctrl_t ctrl_qq;

            always_ff @(posedge pipe_clk) begin
                if (rst_n) begin
                    ctrl_q  <= pipe_tx_ctrl_rst;
                    ctrl_qq <= pipe_tx_ctrl_rst;
                end else begin
                    ctrl_q  <= tx_ctrl_i;
                    ctrl_qq <= ctrl_q;
                end
            end

            assign tx_ctrl_o = ctrl_qq;

        end else begin : g_stages_bad

            $error("pipe_misc supports 0 to 2 stages, got %0d", pipe_stages);

        end
    endgenerate

    // ------------------------------------------------------------------
    // core-side legality.
    // ------------------------------------------------------------------

    // reserved margin codes must never reach the transceiver.
    a_margin_legal: assert property (
        @(posedge pipe_clk) disable iff (rst_n)
        tx_ctrl_i.margin <= margin_max
    ) else $error("tx margin %0d above legal maximum", tx_ctrl_i.margin);

    // receiver detection needs the transmitter out of reset.
    a_det_outside_reset: assert property (
        @(posedge pipe_clk) disable iff (rst_n)
        !(tx_ctrl_i.rcvr_det && tx_ctrl_i.tx_reset)
    ) else $error("receiver detect requested while tx_reset is high");

endmodule

`default_nettype wire

//--- source/pipe_delay_line.sv
`default_nettype none

module pipe_delay_line #(
    parameter type      payload_t   = logic [7:0],
    parameter int       pipe_stages = 1,
    parameter payload_t rst_val     = '0
) (
    input  logic     pipe_clk,
    input  logic     rst_n,
    input  payload_t d_i,
    output payload_t q_o
);

    generate
        if (pipe_stages == 0) begin : g_stages_0

            // no retiming, so reset has no effect here.
            assign q_o = d_i;

        end else if (pipe_stages == 1 || pipe_stages == 2) begin : g_stages_n

            payload_t stage_q [pipe_stages];

            // stage 0 takes the input, later stages shift along.
            always_ff @(posedge pipe_clk) begin
                if (rst_n) begin
                    for (int i = 0; i < pipe_stages; i++) begin
                        stage_q[i] <= rst_val;
                    end
                end else begin
                    stage_q[0] <= d_i;
                    for (int i = 1; i < pipe_stages; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign q_o = stage_q[pipe_stages-1];

        end else begin : g_stages_bad

            $error("pipe_delay_line supports 0 to 2 stages, got %0d", pipe_stages);

        end
    endgenerate

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // ------------------------------------------------------------------
    // lane geometry.
    // ------------------------------------------------------------------

    localparam int num_lanes   = 4;
    localparam int lane_data_w = 16;
    localparam int lane_k_w    = lane_data_w / 8;

    // codes 5 to 7 are reserved.
    localparam logic [2:0] margin_max = 3'd4;

    // ------------------------------------------------------------------
    // shared transmit controls.
    // ------------------------------------------------------------------

    typedef struct packed {
        logic       rcvr_det;
        logic       tx_reset;
        logic       rate;
        logic       deemph;
        logic [2:0] margin;
        logic       swing;
    } pipe_tx_ctrl_t;

    // transmitter held in reset with de-emphasis on.
    localparam pipe_tx_ctrl_t pipe_tx_ctrl_rst = '{
        rcvr_det: 1'b0,
        tx_reset: 1'b1,
        rate:     1'b0,
        deemph:   1'b1,
        margin:   3'd0,
        swing:    1'b0
    };

    // ------------------------------------------------------------------
    // per-lane groups.
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [lane_data_w-1:0] data;
        logic [lane_k_w-1:0]    datak;
        logic                   elec_idle;
        logic                   compliance;
        logic                   polarity;
        logic [1:0]             powerdown;
    } pipe_lane_tx_t;

    // idle lane parked in P1.
    localparam pipe_lane_tx_t pipe_lane_tx_rst = '{
        data:       '0,
        datak:      '0,
        elec_idle:  1'b1,
        compliance: 1'b0,
        polarity:   1'b0,
        powerdown:  2'd2
    };

    typedef struct packed {
        logic [lane_data_w-1:0] data;
        logic [lane_k_w-1:0]    datak;
        logic                   valid;
        logic                   elec_idle;
        logic [2:0]             status;
        logic                   phy_status;
    } pipe_lane_rx_t;

    localparam pipe_lane_rx_t pipe_lane_rx_rst = '{
        data:       '0,
        datak:      '0,
        valid:      1'b0,
        elec_idle:  1'b1,
        status:     3'd0,
        phy_status: 1'b0
    };

endpackage

`default_nettype wire
